// File: common/dcache_consts.svh
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

////////////////////////////////////////////////////////////////////////
// Address split of a 32-bit byte address
////////////////////////////////////////////////////////////////////////

`define DC_ADDR_W   32
`define DC_TAG_W    25
`define DC_INDEX_W  4
// Byte offset within a line of two words
`define DC_OFFSET_W 3

////////////////////////////////////////////////////////////////////////
// Cache geometry
////////////////////////////////////////////////////////////////////////

`define DC_WAYS     2
`define DC_SETS     16
`define DC_WORDS    2

`endif

// File: common/dcache_pkg.sv
`include "dcache_consts.svh"

package dcache_pkg;

    typedef logic [`DC_ADDR_W-1:0]  addr_t;
    typedef logic [`DC_TAG_W-1:0]   tag_t;
    typedef logic [`DC_INDEX_W-1:0] index_t;
    typedef logic [31:0]            word_t;
    typedef logic [`DC_WAYS-1:0]    way_mask_t;

    // Bit 1 requests a clear, bit 0 picks the way
    typedef logic [1:0] tagv_init_t;

    typedef enum logic [1:0] {
        OP_LOAD,
        OP_STORE,
        OP_INVAL
    } dc_op_e;

    typedef struct packed {
        dc_op_e op;
        addr_t  addr;
        word_t  wdata;
    } dc_req_t;

    typedef struct packed {
        word_t rdata;
    } dc_resp_t;

    typedef struct packed {
        addr_t addr;
        word_t wdata;
        logic  write;
    } mem_req_t;

    typedef enum logic [2:0] {
        CS_INIT,
        CS_IDLE,
        CS_LOOKUP,
        CS_REFILL,
        CS_WRITE,
        CS_FINISH
    } ctrl_state_e;

endpackage

// File: tagv/lutram.sv
`include "dcache_consts.svh"

module lutram (
    input  logic               clk,

    // Write port
    input  dcache_pkg::index_t waddr,
    input  dcache_pkg::tag_t   din,
    input  logic               we,

    // Read port with tag compare
    input  dcache_pkg::index_t raddr,
    output dcache_pkg::tag_t   dout,
    input  dcache_pkg::tag_t   din_comp,
    output logic               hit
);

    import dcache_pkg::*;

    tag_t   mem [`DC_SETS];
    index_t raddr_q;

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= din;
        end
    end

    // Read address held for one cycle
    // A write to the same set shows up in dout right away
    always_ff @(posedge clk) begin
        raddr_q <= raddr;
    end

    assign dout = mem[raddr_q];

    // Tag match only, valid bit is added by the caller
    assign hit = (dout == din_comp);

endmodule

// File: tagv/dcache_tagv.sv
`include "dcache_consts.svh"

module dcache_tagv (
    input  logic                   clk,

    // Lookup side
    input  dcache_pkg::index_t     addr_read,
    input  dcache_pkg::tag_t       din_compare,
    output dcache_pkg::way_mask_t  hit,

    // Update side
    input  dcache_pkg::tagv_init_t init,
    input  dcache_pkg::tag_t       din_write,
    input  dcache_pkg::index_t     addr_write,
    input  dcache_pkg::way_mask_t  unvalid,
    input  dcache_pkg::way_mask_t  we
);

    import dcache_pkg::*;

    logic [`DC_SETS-1:0] valid [`DC_WAYS];

    way_mask_t clr;
    way_mask_t v_wr;
    way_mask_t v_new;
    way_mask_t v_q;
    way_mask_t tag_match;

    ////////////////////////////////////////////////////////////////////////
    // Valid bit update, priority init > unvalid > we
    ////////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            clr[w] = init[1] && (init[0] == 1'(w));
            if (init[1]) begin
                v_wr[w]  = clr[w];
                v_new[w] = 1'b0;
            end else begin
                v_wr[w]  = unvalid[w] || we[w];
                v_new[w] = !unvalid[w];
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (v_wr[w]) begin
                valid[w][addr_write] <= v_new[w];
            end
        end
    end

    // Registered valid read
    // Same-set write in this cycle is forwarded
    always_ff @(posedge clk) begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (v_wr[w] && (addr_write == addr_read)) begin
                v_q[w] <= v_new[w];
            end else begin
                v_q[w] <= valid[w][addr_read];
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Tag storage, one lutram per way
    ////////////////////////////////////////////////////////////////////////

    for (genvar w = 0; w < `DC_WAYS; w++) begin : g_way
        lutram u_tags (
            .clk      (clk),
            .waddr    (addr_write),
            .din      (clr[w] ? '0 : din_write),
            .we       (we[w] || clr[w]),
            .raddr    (addr_read),
            .dout     (),
            .din_comp (din_compare),
            .hit      (tag_match[w])
        );
    end

    assign hit = tag_match & v_q;

    // Init sweep and refill never overlap
    a_init_no_we: assert property (@(posedge clk) init[1] |-> (we == '0));

endmodule

// File: hdl/dcache_data.sv
`include "dcache_consts.svh"

module dcache_data (
    input  logic                  clk,

    // Read port, both ways at once
    input  dcache_pkg::index_t    raddr,
    output dcache_pkg::word_t [`DC_WAYS-1:0][`DC_WORDS-1:0] rdata,

    // Word write into the masked ways
    input  dcache_pkg::index_t    waddr,
    input  logic                  wword,
    input  dcache_pkg::way_mask_t wmask,
    input  dcache_pkg::word_t     wdata
);

    import dcache_pkg::*;

    word_t  mem [`DC_WAYS][`DC_SETS][`DC_WORDS];
    index_t raddr_q;

    always_ff @(posedge clk) begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (wmask[w]) begin
                mem[w][waddr][wword] <= wdata;
            end
        end
    end

    // Read index registered, so a refill word is visible next cycle
    always_ff @(posedge clk) begin
        raddr_q <= raddr;
    end

    always_comb begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            for (int k = 0; k < `DC_WORDS; k++) begin
                rdata[w][k] = mem[w][raddr_q][k];
            end
        end
    end

    // Store hit or refill targets a single way
    a_wmask_onehot: assert property (@(posedge clk) wmask[0] |-> !wmask[1]);

endmodule

// File: hdl/dcache_lru.sv
`include "dcache_consts.svh"

module dcache_lru (
    input  logic               clk,
    input  logic               rst,
    input  dcache_pkg::index_t index,
    input  logic               touch,
    input  logic               touch_way,
    output logic               victim
);

    import dcache_pkg::*;

    // One bit per set, the way to evict next
    logic [`DC_SETS-1:0] next_way;

    always_ff @(posedge clk) begin
        if (rst) begin
            next_way <= '0;
        end else if (touch) begin
            next_way[index] <= !touch_way;
        end
    end

    assign victim = next_way[index];

endmodule

// File: hdl/dcache_ctrl.sv
`include "dcache_consts.svh"

module dcache_ctrl (
    input  logic                   clk,
    input  logic                   rst,

    // CPU side
    input  logic                   req,
    input  dcache_pkg::dc_req_t    req_data,
    output logic                   busy,
    output logic                   resp_valid,
    output dcache_pkg::dc_resp_t   resp_data,

    // Tag array
    output dcache_pkg::index_t     tag_raddr,
    output dcache_pkg::tag_t       tag_cmp,
    output dcache_pkg::index_t     tag_waddr,
    output dcache_pkg::tag_t       tag_wtag,
    output dcache_pkg::way_mask_t  tag_we,
    output dcache_pkg::way_mask_t  tag_unvalid,
    output dcache_pkg::tagv_init_t tag_init,
    input  dcache_pkg::way_mask_t  tag_hit,

    // Data array
    output dcache_pkg::index_t     data_raddr,
    output dcache_pkg::index_t     data_waddr,
    output logic                   data_wword,
    output dcache_pkg::way_mask_t  data_wmask,
    output dcache_pkg::word_t      data_wdata,
    input  dcache_pkg::word_t [`DC_WAYS-1:0][`DC_WORDS-1:0] data_rdata,

    // LRU
    output dcache_pkg::index_t     lru_index,
    output logic                   lru_touch,
    output logic                   lru_touch_way,
    input  logic                   lru_victim,

    // Memory side
    output logic                   mem_valid,
    output dcache_pkg::mem_req_t   mem_req,
    input  logic                   mem_ack,
    input  dcache_pkg::word_t      mem_rdata
);

    import dcache_pkg::*;

    ctrl_state_e         state;
    dc_req_t             req_q;
    logic [`DC_INDEX_W:0] init_cnt;
    logic                refill_word;
    logic                victim_q;

    logic      accept;
    logic      in_lookup;
    logic      in_refill;
    tag_t      req_tag;
    index_t    req_index;
    logic      req_word;
    logic      hit_any;
    logic      hit_way;
    logic      ack_word;
    logic      refill_done;
    way_mask_t victim_mask;

    assign busy       = !(state == CS_IDLE || state == CS_FINISH);
    assign resp_valid = (state == CS_FINISH);
    assign accept     = req && !busy;
    assign in_lookup  = (state == CS_LOOKUP);
    assign in_refill  = (state == CS_REFILL);

    assign req_tag   = req_q.addr[`DC_ADDR_W-1 -: `DC_TAG_W];
    assign req_index = req_q.addr[`DC_OFFSET_W +: `DC_INDEX_W];
    assign req_word  = req_q.addr[`DC_OFFSET_W-1];

    assign hit_any     = |tag_hit;
    assign hit_way     = tag_hit[1];
    assign ack_word    = in_refill && mem_valid && mem_ack;
    assign refill_done = ack_word && refill_word;
    assign victim_mask = way_mask_t'(1'b1) << victim_q;

    ////////////////////////////////////////////////////////////////////////
    // FSM
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= CS_INIT;
            init_cnt    <= '0;
            refill_word <= 1'b0;
            mem_valid   <= 1'b0;
        end else begin
            case (state)
                // Way 0 sets first, then way 1
                CS_INIT: begin
                    init_cnt <= init_cnt + 1'b1;
                    if (&init_cnt) begin
                        state <= CS_IDLE;
                    end
                end
                CS_IDLE, CS_FINISH: begin
                    state <= accept ? CS_LOOKUP : CS_IDLE;
                end
                CS_LOOKUP: begin
                    if (req_q.op == OP_STORE) begin
                        state     <= CS_WRITE;
                        mem_valid <= 1'b1;
                    end else if (req_q.op == OP_LOAD && !hit_any) begin
                        state       <= CS_REFILL;
                        mem_valid   <= 1'b1;
                        refill_word <= 1'b0;
                    end else begin
                        state <= CS_FINISH;
                    end
                end
                // One idle cycle between the two word reads
                CS_REFILL: begin
                    if (ack_word) begin
                        mem_valid <= 1'b0;
                        if (refill_word) begin
                            state <= CS_LOOKUP;
                        end else begin
                            refill_word <= 1'b1;
                        end
                    end else begin
                        mem_valid <= 1'b1;
                    end
                end
                CS_WRITE: begin
                    if (mem_valid && mem_ack) begin
                        mem_valid <= 1'b0;
                        state     <= CS_FINISH;
                    end
                end
                default: state <= CS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req_data;
        end
        if (in_lookup && !hit_any) begin
            victim_q <= lru_victim;
        end
        if (in_lookup) begin
            resp_data.rdata <= (req_q.op == OP_LOAD) ? data_rdata[hit_way][req_word] : '0;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Array and memory controls
    ////////////////////////////////////////////////////////////////////////

    // Arrays see the incoming index while a request can be taken
    assign tag_raddr = busy ? req_index : req_data.addr[`DC_OFFSET_W +: `DC_INDEX_W];
    assign tag_cmp   = req_tag;
    assign tag_waddr = (state == CS_INIT) ? init_cnt[`DC_INDEX_W-1:0] : req_index;
    assign tag_wtag  = req_tag;
    assign tag_we    = refill_done ? victim_mask : '0;
    assign tag_init  = (state == CS_INIT) ? {1'b1, init_cnt[`DC_INDEX_W]} : 2'b00;

    assign tag_unvalid = (in_lookup && req_q.op == OP_INVAL) ? tag_hit : '0;

    assign data_raddr = tag_raddr;
    assign data_waddr = req_index;
    assign data_wword = in_refill ? refill_word : req_word;
    assign data_wdata = in_refill ? mem_rdata : req_q.wdata;

    always_comb begin
        if (ack_word) begin
            data_wmask = victim_mask;
        end else if (in_lookup && req_q.op == OP_STORE) begin
            data_wmask = tag_hit;
        end else begin
            data_wmask = '0;
        end
    end

    assign lru_index     = req_index;
    assign lru_touch     = refill_done || (in_lookup && hit_any && req_q.op != OP_INVAL);
    assign lru_touch_way = in_refill ? victim_q : hit_way;

    assign mem_req.addr  = in_refill ?
                           {req_tag, req_index, refill_word, {(`DC_OFFSET_W-1){1'b0}}} :
                           req_q.addr;
    assign mem_req.wdata = req_q.wdata;
    assign mem_req.write = (state == CS_WRITE);

    a_mem_req_stable: assert property (@(posedge clk) disable iff (rst)
        (mem_valid && !mem_ack) |=> (mem_valid && $stable(mem_req)));

endmodule

// File: hdl/dcache_top.sv
`include "dcache_consts.svh"

module dcache_top (
    input  logic                 clk,
    input  logic                 rst,

    input  logic                 req,
    input  dcache_pkg::dc_req_t  req_data,
    output logic                 busy,
    output logic                 resp_valid,
    output dcache_pkg::dc_resp_t resp_data,

    output logic                 mem_valid,
    output dcache_pkg::mem_req_t mem_req,
    input  logic                 mem_ack,
    input  dcache_pkg::word_t    mem_rdata
);

    import dcache_pkg::*;

    index_t     tag_raddr;
    index_t     tag_waddr;
    tag_t       tag_cmp;
    tag_t       tag_wtag;
    way_mask_t  tag_hit;
    way_mask_t  tag_we;
    way_mask_t  tag_unvalid;
    tagv_init_t tag_init;

    index_t     data_raddr;
    index_t     data_waddr;
    logic       data_wword;
    way_mask_t  data_wmask;
    word_t      data_wdata;
    word_t [`DC_WAYS-1:0][`DC_WORDS-1:0] data_rdata;

    index_t     lru_index;
    logic       lru_touch;
    logic       lru_touch_way;
    logic       lru_victim;

    dcache_ctrl u_ctrl (
        .clk (clk), .rst (rst),
        .req (req), .req_data (req_data), .busy (busy),
        .resp_valid (resp_valid), .resp_data (resp_data),
        .tag_raddr (tag_raddr), .tag_cmp (tag_cmp), .tag_waddr (tag_waddr),
        .tag_wtag (tag_wtag), .tag_we (tag_we), .tag_unvalid (tag_unvalid),
        .tag_init (tag_init), .tag_hit (tag_hit),
        .data_raddr (data_raddr), .data_waddr (data_waddr), .data_wword (data_wword),
        .data_wmask (data_wmask), .data_wdata (data_wdata), .data_rdata (data_rdata),
        .lru_index (lru_index), .lru_touch (lru_touch),
        .lru_touch_way (lru_touch_way), .lru_victim (lru_victim),
        .mem_valid (mem_valid), .mem_req (mem_req),
        .mem_ack (mem_ack), .mem_rdata (mem_rdata)
    );

    dcache_tagv u_tagv (
        .clk (clk), .addr_read (tag_raddr), .din_compare (tag_cmp), .hit (tag_hit),
        .init (tag_init), .din_write (tag_wtag), .addr_write (tag_waddr),
        .unvalid (tag_unvalid), .we (tag_we)
    );

    dcache_data u_data (
        .clk (clk), .raddr (data_raddr), .rdata (data_rdata), .waddr (data_waddr),
        .wword (data_wword), .wmask (data_wmask), .wdata (data_wdata)
    );

    dcache_lru u_lru (
        .clk (clk), .rst (rst), .index (lru_index), .touch (lru_touch),
        .touch_way (lru_touch_way), .victim (lru_victim)
    );

endmodule

// File: tests/clk_gen.sv
module clk_gen #(
    parameter int HALF_PERIOD  = 10,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic rst
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

    // Reset released on a falling edge, like the other DUT inputs
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst <= 1'b0;
    end

endmodule

// File: tests/tb_mem_model.sv
module tb_mem_model #(
    parameter int          DELAY = 3,
    parameter logic [31:0] SEED  = 32'h5de3
) (
    input  logic                 clk,
    input  logic                 mem_valid,
    input  dcache_pkg::mem_req_t mem_req,
    output logic                 mem_ack,
    output dcache_pkg::word_t    mem_rdata,
    output int                   read_count,
    output int                   write_count
);

    timeunit 1ns;
    timeprecision 100ps;

    import dcache_pkg::*;

    localparam int MEM_AW    = 8;
    localparam int MEM_WORDS = 1 << MEM_AW;

    word_t words [MEM_WORDS];
    int    wait_cnt;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Each word gets the next LCG value, so the fill follows the address
    initial begin
        logic [31:0] s;
        mem_ack     = 1'b0;
        mem_rdata   = '0;
        read_count  = 0;
        write_count = 0;
        wait_cnt    = 0;
        s = SEED;
        for (int i = 0; i < MEM_WORDS; i++) begin
            s = lcg_next(s);
            words[i] = s;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Fixed-delay responder, ack is a single-cycle pulse
    ////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (mem_ack) begin
            mem_ack  = 1'b0;
            wait_cnt = 0;
        end else if (mem_valid) begin
            wait_cnt = wait_cnt + 1;
            if (wait_cnt == DELAY) begin
                if (mem_req.write) begin
                    words[mem_req.addr[MEM_AW+1:2]] = mem_req.wdata;
                    write_count = write_count + 1;
                end else begin
                    mem_rdata  = words[mem_req.addr[MEM_AW+1:2]];
                    read_count = read_count + 1;
                end
                mem_ack = 1'b1;
            end
        end else begin
            wait_cnt = 0;
        end
    end

endmodule

// File: tests/tb_dcache.sv
`include "dcache_consts.svh"

module tb_dcache;

    timeunit 1ns;
    timeprecision 100ps;

    import dcache_pkg::*;

    localparam int N_TESTS     = 22;
    localparam int CYCLE_LIMIT = 200 * N_TESTS + 100;
    localparam int MEM_AW      = 8;
    localparam int MEM_WORDS   = 1 << MEM_AW;

    logic     clk;
    logic     rst;
    logic     req;
    dc_req_t  req_data;
    logic     busy;
    logic     resp_valid;
    dc_resp_t resp_data;
    logic     mem_valid;
    mem_req_t mem_req;
    logic     mem_ack;
    word_t    mem_rdata;
    int       read_count;
    int       write_count;

    // Stimulus table
    string  t_name  [N_TESTS];
    dc_op_e t_op    [N_TESTS];
    addr_t  t_addr  [N_TESTS];
    word_t  t_wdata [N_TESTS];
    int     t_reads [N_TESTS];
    bit     t_check [N_TESTS];
    int     n_entries;

    // Reference cache and memory
    tag_t  ref_tag   [`DC_WAYS][`DC_SETS];
    bit    ref_valid [`DC_WAYS][`DC_SETS];
    bit    ref_lru   [`DC_SETS];
    word_t mem_copy  [MEM_WORDS];

    int errors;
    int tests_run;
    int tests_failed;
    int cycles;

    clk_gen u_clk (
        .clk (clk),
        .rst (rst)
    );

    tb_mem_model #(.DELAY(3), .SEED(32'h5de3)) mem0 (
        .clk         (clk),
        .mem_valid   (mem_valid),
        .mem_req     (mem_req),
        .mem_ack     (mem_ack),
        .mem_rdata   (mem_rdata),
        .read_count  (read_count),
        .write_count (write_count)
    );

    dcache_top dut0 (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .req_data   (req_data),
        .busy       (busy),
        .resp_valid (resp_valid),
        .resp_data  (resp_data),
        .mem_valid  (mem_valid),
        .mem_req    (mem_req),
        .mem_ack    (mem_ack),
        .mem_rdata  (mem_rdata)
    );

    task automatic add_entry(input string name, input dc_op_e op, input addr_t addr,
                             input word_t wdata, input int reads, input bit chk);
        t_name[n_entries]  = name;
        t_op[n_entries]    = op;
        t_addr[n_entries]  = addr;
        t_wdata[n_entries] = wdata;
        t_reads[n_entries] = reads;
        t_check[n_entries] = chk;
        n_entries++;
    endtask

    task automatic fill_table();
        n_entries = 0;
        add_entry("load_cold",               OP_LOAD,  32'h010, '0,           2, 1'b1);
        add_entry("load_hit_word1",          OP_LOAD,  32'h014, '0,           0, 1'b1);
        add_entry("load_hit_word0",          OP_LOAD,  32'h010, '0,           0, 1'b1);
        add_entry("store_hit",               OP_STORE, 32'h014, 32'hcafe0001, 0, 1'b1);
        add_entry("load_after_store_hit",    OP_LOAD,  32'h014, '0,           0, 1'b1);
        add_entry("store_miss",              OP_STORE, 32'h020, 32'h12345678, 0, 1'b1);
        add_entry("load_after_store_miss",   OP_LOAD,  32'h020, '0,           2, 1'b1);
        // Set 8 with tags 0, 1 and 2
        add_entry("fill_a",                  OP_LOAD,  32'h040, '0,           2, 1'b1);
        add_entry("fill_b",                  OP_LOAD,  32'h0c0, '0,           2, 1'b1);
        add_entry("touch_a",                 OP_LOAD,  32'h044, '0,           0, 1'b1);
        add_entry("fill_c_evicts_b",         OP_LOAD,  32'h144, '0,           2, 1'b1);
        add_entry("a_still_cached",          OP_LOAD,  32'h040, '0,           0, 1'b1);
        add_entry("b_misses_again",          OP_LOAD,  32'h0c4, '0,           2, 1'b1);
        add_entry("c_evicts_a",              OP_LOAD,  32'h140, '0,           2, 1'b1);
        add_entry("store_hit_way1",          OP_STORE, 32'h0c0, 32'h0badf00d, 0, 1'b1);
        add_entry("load_hit_way1",           OP_LOAD,  32'h0c0, '0,           0, 1'b1);
        add_entry("a_misses_again",          OP_LOAD,  32'h044, '0,           2, 1'b1);
        add_entry("inval_cached",            OP_INVAL, 32'h010, '0,           0, 1'b1);
        add_entry("load_after_inval",        OP_LOAD,  32'h010, '0,           2, 1'b1);
        add_entry("inval_absent",            OP_INVAL, 32'h300, '0,           0, 1'b1);
        add_entry("load_after_inval_absent", OP_LOAD,  32'h304, '0,           2, 1'b1);
        add_entry("load_last_set",           OP_LOAD,  32'h3fc, '0,           2, 1'b1);
    endtask

    ////////////////////////////////////////////////////////////////////
    // Reference model, two ways with one LRU bit per set
    ////////////////////////////////////////////////////////////////////

    task automatic model_step(input dc_op_e op, input addr_t addr, input word_t wdata,
                              output int reads, output int writes, output word_t rdata);
        index_t idx;
        tag_t   tag;
        int     hit_way;
        int     v;
        idx     = addr[`DC_OFFSET_W +: `DC_INDEX_W];
        tag     = addr[`DC_ADDR_W-1 -: `DC_TAG_W];
        hit_way = -1;
        reads   = 0;
        writes  = 0;
        rdata   = '0;
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (ref_valid[w][idx] && ref_tag[w][idx] == tag) begin
                hit_way = w;
            end
        end
        case (op)
            OP_LOAD: begin
                if (hit_way < 0) begin
                    // Victim is whatever the LRU bit names, valid or not
                    v = ref_lru[idx];
                    ref_tag[v][idx]   = tag;
                    ref_valid[v][idx] = 1'b1;
                    hit_way = v;
                    reads   = `DC_WORDS;
                end
                ref_lru[idx] = (hit_way == 0);
                rdata = mem_copy[addr[MEM_AW+1:2]];
            end
            OP_STORE: begin
                // No allocate on a miss
                if (hit_way >= 0) begin
                    ref_lru[idx] = (hit_way == 0);
                end
                mem_copy[addr[MEM_AW+1:2]] = wdata;
                writes = 1;
            end
            default: begin
                if (hit_way >= 0) begin
                    ref_valid[hit_way][idx] = 1'b0;
                end
            end
        endcase
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("PASS %s", name);
        end else begin
            tests_failed++;
            $display("FAIL %s", name);
        end
    endtask

    task automatic run_entry(input int i);
        int    reads0;
        int    writes0;
        int    exp_reads;
        int    exp_writes;
        word_t exp_rdata;
        int    latency;
        int    errs0;
        errs0 = errors;
        while (busy) begin
            @(negedge clk);
        end
        model_step(t_op[i], t_addr[i], t_wdata[i], exp_reads, exp_writes, exp_rdata);
        if (exp_reads != t_reads[i]) begin
            $display("%s: reference model predicts %0d reads but the table lists %0d",
                     t_name[i], exp_reads, t_reads[i]);
            errors++;
        end
        reads0         = read_count;
        writes0        = write_count;
        req            = 1'b1;
        req_data.op    = t_op[i];
        req_data.addr  = t_addr[i];
        req_data.wdata = t_wdata[i];
        @(negedge clk);
        req     = 1'b0;
        latency = 1;
        while (!resp_valid) begin
            @(negedge clk);
            latency++;
        end
        if (read_count - reads0 != t_reads[i]) begin
            $display("[ERROR] %s: memory reads expected %0d, actual %0d",
                     t_name[i], t_reads[i], read_count - reads0);
            errors++;
        end
        if (write_count - writes0 != exp_writes) begin
            $display("[ERROR] %s: memory writes expected %0d, actual %0d",
                     t_name[i], exp_writes, write_count - writes0);
            errors++;
        end
        if (t_check[i] && resp_data.rdata !== exp_rdata) begin
            $display("[ERROR] %s: rdata expected 32'h%08h, actual 32'h%08h",
                     t_name[i], exp_rdata, resp_data.rdata);
            errors++;
        end
        // Hits and invalidates answer two cycles after req
        if (t_reads[i] == 0 && t_op[i] != OP_STORE && latency != 2) begin
            $display("[ERROR] %s: response latency expected 2, actual %0d",
                     t_name[i], latency);
            errors++;
        end
        if (t_op[i] == OP_STORE &&
            mem0.words[t_addr[i][MEM_AW+1:2]] !== mem_copy[t_addr[i][MEM_AW+1:2]]) begin
            $display("[ERROR] %s: memory word expected 32'h%08h, actual 32'h%08h",
                     t_name[i], mem_copy[t_addr[i][MEM_AW+1:2]],
                     mem0.words[t_addr[i][MEM_AW+1:2]]);
            errors++;
        end
        report_test(t_name[i], errs0);
    endtask

    ////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////

    initial begin
        int init_cycles;
        int errs0;
        req          = 1'b0;
        req_data     = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        for (int w = 0; w < `DC_WAYS; w++) begin
            for (int s = 0; s < `DC_SETS; s++) begin
                ref_tag[w][s]   = '0;
                ref_valid[w][s] = 1'b0;
            end
        end
        for (int s = 0; s < `DC_SETS; s++) begin
            ref_lru[s] = 1'b0;
        end
        fill_table();

        // First falling edge that sees rst low
        @(negedge clk);
        while (rst) begin
            @(negedge clk);
        end
        for (int k = 0; k < MEM_WORDS; k++) begin
            mem_copy[k] = mem0.words[k];
        end
        errs0 = errors;
        if (!busy || mem_valid || resp_valid) begin
            $display("init_sweep: busy low or a strobe active right after reset");
            errors++;
        end
        init_cycles = 1;
        while (busy) begin
            @(negedge clk);
            init_cycles++;
        end
        if (init_cycles != `DC_WAYS * `DC_SETS) begin
            $display("[ERROR] init_sweep: busy cycles expected %0d, actual %0d",
                     `DC_WAYS * `DC_SETS, init_cycles);
            errors++;
        end
        report_test("init_sweep", errs0);

        // Each entry starts in the cycle the previous one answers
        for (int i = 0; i < n_entries; i++) begin
            run_entry(i);
        end

        $display("Summary: %0d tests run, %0d failed, %0d errors",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Run limit
    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: run stopped after %0d cycles without finishing", cycles);
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: project.f
+incdir+common
common/dcache_pkg.sv
tagv/lutram.sv
tagv/dcache_tagv.sv
hdl/dcache_data.sv
hdl/dcache_lru.sv
hdl/dcache_ctrl.sv
hdl/dcache_top.sv
tests/clk_gen.sv
tests/tb_mem_model.sv
tests/tb_dcache.sv
